//--- include/fetch_front_defines.svh
`ifndef FETCH_FRONT_DEFINES_SVH
`define FETCH_FRONT_DEFINES_SVH

// op queue geometry, one slot always left unused
`define FOQ_SIZE 8
`define FOQ_SIZE_W 3

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- verilog/fetch_front_pkg.sv
`default_nettype none

package fetch_front_pkg;

  // one instruction word seen through each base format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_word_u;

  // OP_ILLEGAL must stay at zero, the decoder relies on it
  typedef enum logic [5:0] {
    OP_ILLEGAL, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
  } op_kind_e;

  typedef struct packed {
    op_kind_e    op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        branch;
    logic        ls;
    logic        use_imm;
    logic        jalr;
    logic [31:0] addr;
  } decoded_op_t;

endpackage

`default_nettype wire

//--- verilog/pc_counter.sv
`default_nettype none

`include "fetch_front_defines.svh"

module pc_counter (
  input  logic        clk_in,
  input  logic        arst_n,
  input  logic        rdy,
  input  logic        advance,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  output logic [31:0] fetch_pc
);

  // redirect wins over a normal step
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      fetch_pc <= `RESET_PC;
    end else if (rdy) begin
      if (redirect) begin
        fetch_pc <= redirect_pc;
      end else if (advance) begin
        fetch_pc <= fetch_pc + 32'd4;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl (
  input  logic clk_in,
  input  logic arst_n,
  input  logic rdy,
  input  logic imem_valid,
  input  logic queue_full,
  input  logic flush,
  output logic imem_req,
  output logic advance,
  output logic push
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_WAIT    = 2'd1;
  localparam logic [1:0] ST_DISCARD = 2'd2;

  logic [1:0] state;
  logic [1:0] state_next;
  logic       accept;

  // no request while flushing, pc still holds the old address
  assign imem_req = rdy && (state == ST_IDLE) && !queue_full && !flush;

  // a response landing with a flush belongs to the old stream
  assign accept  = rdy && (state == ST_WAIT) && imem_valid && !flush;
  assign push    = accept;
  assign advance = accept;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (imem_req) begin
          state_next = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (imem_valid) begin
          state_next = ST_IDLE;
        end else if (flush) begin
          state_next = ST_DISCARD;
        end
      end
      ST_DISCARD: begin
        // swallow the stale word
        if (imem_valid) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else if (rdy) begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

//--- verilog/inst_decoder.sv
`default_nettype none

module inst_decoder import fetch_front_pkg::*; (
  input  inst_word_u  inst,
  input  logic [31:0] pc,
  output decoded_op_t op
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [2:0]  f3;
  logic [6:0]  f7;

  assign f3 = inst.r_fmt.funct3;
  assign f7 = inst.r_fmt.funct7;

  // sign-extended immediates, one per format view
  assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_b = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                  inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {inst.u_fmt.imm_31_12, 12'h000};
  assign imm_j = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                  inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    op = '0;
    case (inst.r_fmt.opcode)
      OPC_LUI, OPC_AUIPC: begin
        op.op      = (inst.u_fmt.opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
        op.rd      = inst.u_fmt.rd;
        op.imm     = imm_u;
        op.use_imm = 1'b1;
      end
      OPC_JAL: begin
        op.op      = OP_JAL;
        op.rd      = inst.j_fmt.rd;
        op.imm     = imm_j;
        op.use_imm = 1'b1;
      end
      OPC_JALR: begin
        op.op      = (f3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
        op.rd      = inst.i_fmt.rd;
        op.rs1     = inst.i_fmt.rs1;
        op.imm     = imm_i;
        op.use_imm = 1'b1;
        op.jalr    = 1'b1;
      end
      OPC_BRANCH: begin
        case (f3)
          3'b000:  op.op = OP_BEQ;
          3'b001:  op.op = OP_BNE;
          3'b100:  op.op = OP_BLT;
          3'b101:  op.op = OP_BGE;
          3'b110:  op.op = OP_BLTU;
          3'b111:  op.op = OP_BGEU;
          default: op.op = OP_ILLEGAL;
        endcase
        op.rs1    = inst.b_fmt.rs1;
        op.rs2    = inst.b_fmt.rs2;
        op.imm    = imm_b;
        op.branch = 1'b1;
      end
      OPC_LOAD: begin
        case (f3)
          3'b000:  op.op = OP_LB;
          3'b001:  op.op = OP_LH;
          3'b010:  op.op = OP_LW;
          3'b100:  op.op = OP_LBU;
          3'b101:  op.op = OP_LHU;
          default: op.op = OP_ILLEGAL;
        endcase
        op.rd      = inst.i_fmt.rd;
        op.rs1     = inst.i_fmt.rs1;
        op.imm     = imm_i;
        op.ls      = 1'b1;
        op.use_imm = 1'b1;
      end
      OPC_STORE: begin
        case (f3)
          3'b000:  op.op = OP_SB;
          3'b001:  op.op = OP_SH;
          3'b010:  op.op = OP_SW;
          default: op.op = OP_ILLEGAL;
        endcase
        op.rs1     = inst.s_fmt.rs1;
        op.rs2     = inst.s_fmt.rs2;
        op.imm     = imm_s;
        op.ls      = 1'b1;
        op.use_imm = 1'b1;
      end
      OPC_OPIMM: begin
        // shifts keep funct7 inside the I immediate
        case (f3)
          3'b000:  op.op = OP_ADDI;
          3'b010:  op.op = OP_SLTI;
          3'b011:  op.op = OP_SLTIU;
          3'b100:  op.op = OP_XORI;
          3'b110:  op.op = OP_ORI;
          3'b111:  op.op = OP_ANDI;
          3'b001:  op.op = (f7 == 7'b0000000) ? OP_SLLI : OP_ILLEGAL;
          default: begin
            if (f7 == 7'b0000000) begin
              op.op = OP_SRLI;
            end else if (f7 == 7'b0100000) begin
              op.op = OP_SRAI;
            end else begin
              op.op = OP_ILLEGAL;
            end
          end
        endcase
        op.rd      = inst.i_fmt.rd;
        op.rs1     = inst.i_fmt.rs1;
        op.imm     = imm_i;
        op.use_imm = 1'b1;
      end
      OPC_OP: begin
        case ({f7, f3})
          {7'b0000000, 3'b000}: op.op = OP_ADD;
          {7'b0100000, 3'b000}: op.op = OP_SUB;
          {7'b0000000, 3'b001}: op.op = OP_SLL;
          {7'b0000000, 3'b010}: op.op = OP_SLT;
          {7'b0000000, 3'b011}: op.op = OP_SLTU;
          {7'b0000000, 3'b100}: op.op = OP_XOR;
          {7'b0000000, 3'b101}: op.op = OP_SRL;
          {7'b0100000, 3'b101}: op.op = OP_SRA;
          {7'b0000000, 3'b110}: op.op = OP_OR;
          {7'b0000000, 3'b111}: op.op = OP_AND;
          default:              op.op = OP_ILLEGAL;
        endcase
        op.rd  = inst.r_fmt.rd;
        op.rs1 = inst.r_fmt.rs1;
        op.rs2 = inst.r_fmt.rs2;
      end
      default: begin
        op.op = OP_ILLEGAL;
      end
    endcase
    // unknown encodings carry nothing but their address
    if (op.op == OP_ILLEGAL) begin
      op = '0;
    end
    op.addr = pc;
  end

endmodule

`default_nettype wire

//--- verilog/op_queue.sv
`default_nettype none

`include "fetch_front_defines.svh"

module op_queue import fetch_front_pkg::*; (
  input  logic        clk_in,
  input  logic        arst_n,
  input  logic        rdy,
  input  logic        push,
  input  logic        flush,
  input  logic        stall,
  input  decoded_op_t in_op,
  output decoded_op_t out_op,
  output logic        out_valid,
  output logic        full
);

  decoded_op_t slots [`FOQ_SIZE];

  logic [`FOQ_SIZE_W-1:0] front;
  logic [`FOQ_SIZE_W-1:0] rear;
  logic                   do_pop;
  logic                   do_push;

  function automatic logic [`FOQ_SIZE_W-1:0] next_ptr(input logic [`FOQ_SIZE_W-1:0] ptr);
    if (ptr == `FOQ_SIZE_W'(`FOQ_SIZE - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // one slot stays empty so front == rear always means empty
  assign out_valid = (front != rear);
  assign full      = (next_ptr(rear) == front);
  assign out_op    = out_valid ? slots[front] : '0;

  // head is held while the issue stage stalls
  assign do_pop  = out_valid && !stall;
  assign do_push = push && !full;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      front <= '0;
      rear  <= '0;
    end else if (rdy) begin
      if (flush) begin
        front <= '0;
        rear  <= '0;
      end else begin
        if (do_pop) begin
          front <= next_ptr(front);
        end
        if (do_push) begin
          rear <= next_ptr(rear);
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy && do_push && !flush) begin
      slots[rear] <= in_op;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetch_front.sv
`default_nettype none

module fetch_front import fetch_front_pkg::*; (
  input  logic        clk_in,
  input  logic        arst_n,
  input  logic        rdy,
  output logic        imem_req,
  output logic [31:0] imem_addr,
  input  logic        imem_valid,
  input  logic [31:0] imem_data,
  input  logic        predict_fail,
  input  logic [31:0] redirect_pc,
  output decoded_op_t issue_op,
  output logic        issue_valid,
  input  logic        issue_stall,
  output logic        queue_full
);

  logic [31:0] fetch_pc;
  logic        advance;
  logic        push;
  decoded_op_t dec_op;

  // pc is held until the response is pushed
  assign imem_addr = fetch_pc;

  pc_counter u_pc_counter (
    .clk_in      (clk_in),
    .arst_n      (arst_n),
    .rdy         (rdy),
    .advance     (advance),
    .redirect    (predict_fail),
    .redirect_pc (redirect_pc),
    .fetch_pc    (fetch_pc)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk_in     (clk_in),
    .arst_n     (arst_n),
    .rdy        (rdy),
    .imem_valid (imem_valid),
    .queue_full (queue_full),
    .flush      (predict_fail),
    .imem_req   (imem_req),
    .advance    (advance),
    .push       (push)
  );

  inst_decoder u_inst_decoder (
    .inst (inst_word_u'(imem_data)),
    .pc   (fetch_pc),
    .op   (dec_op)
  );

  op_queue u_op_queue (
    .clk_in    (clk_in),
    .arst_n    (arst_n),
    .rdy       (rdy),
    .push      (push),
    .flush     (predict_fail),
    .stall     (issue_stall),
    .in_op     (dec_op),
    .out_op    (issue_op),
    .out_valid (issue_valid),
    .full      (queue_full)
  );

endmodule

`default_nettype wire

//--- bench/imem_model.sv
`default_nettype none

module imem_model #(
  parameter logic [31:0] SEED = 32'h6d5bd296
) (
  input  logic        clk_in,
  input  logic        arst_n,
  input  logic        rdy,
  input  logic        imem_req,
  input  logic [31:0] imem_addr,
  output logic        imem_valid,
  output logic [31:0] imem_data
);

  timeunit 1ns;
  timeprecision 1ps;

  // instruction image, loaded by the testbench before reset ends
  logic [31:0] words [16];

  integer seed = SEED;
  int     wait_cnt;
  int     lat;
  logic   busy;

  always @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      imem_valid <= 1'b0;
      imem_data  <= '0;
      busy       <= 1'b0;
      wait_cnt   <= 0;
    end else if (imem_valid) begin
      // response stays up until an edge with rdy high takes it
      if (rdy) begin
        imem_valid <= 1'b0;
        busy       <= 1'b0;
      end
    end else if (busy) begin
      if (wait_cnt <= 1) begin
        imem_valid <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end else if (imem_req) begin
      // latency of 1 to 4 cycles
      lat = ($random(seed) & 3) + 1;
      busy      <= 1'b1;
      imem_data <= words[imem_addr[5:2]];
      if (lat == 1) begin
        imem_valid <= 1'b1;
      end else begin
        wait_cnt <= lat - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/fetch_front_tb.sv
`default_nettype none

`include "fetch_front_defines.svh"

module fetch_front_tb import fetch_front_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROWS        = 16;
  localparam int MODE_STEADY = 0;
  localparam int MODE_HOLD   = 1;
  localparam int MODE_RANDOM = 2;
  // 16 + 16 + 32 + 28 ops popped over all tests
  localparam int TOTAL_OPS   = 92;
  localparam int CYCLE_LIMIT = 40 * TOTAL_OPS;

  logic        clk_in;
  logic        arst_n;
  logic        rdy;
  logic        imem_req;
  logic [31:0] imem_addr;
  logic        imem_valid;
  logic [31:0] imem_data;
  logic        predict_fail;
  logic [31:0] redirect_pc;
  decoded_op_t issue_op;
  logic        issue_valid;
  logic        issue_stall;
  logic        queue_full;

  logic [31:0] row_word [ROWS];
  decoded_op_t row_op [ROWS];

  integer      seed = 32'h6d5bd296;
  int          mode = MODE_STEADY;
  logic        flush_req = 1'b0;
  logic [31:0] flush_pc = '0;
  logic [31:0] exp_addr = `RESET_PC;
  logic        after_flush = 1'b0;
  int          pop_count = 0;
  int          req_count = 0;
  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          test_num = 0;
  int          tests_failed = 0;
  int          err_start = 0;

  fetch_front DUT (
    .clk_in       (clk_in),
    .arst_n       (arst_n),
    .rdy          (rdy),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .imem_valid   (imem_valid),
    .imem_data    (imem_data),
    .predict_fail (predict_fail),
    .redirect_pc  (redirect_pc),
    .issue_op     (issue_op),
    .issue_valid  (issue_valid),
    .issue_stall  (issue_stall),
    .queue_full   (queue_full)
  );

  imem_model u_imem (
    .clk_in     (clk_in),
    .arst_n     (arst_n),
    .rdy        (rdy),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_valid (imem_valid),
    .imem_data  (imem_data)
  );

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    inst_word_u w;
    w.r_fmt = {f7, rs2, rs1, f3, rd, opc};
    return w;
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    inst_word_u w;
    w.i_fmt = {imm, rs1, f3, rd, opc};
    return w;
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    inst_word_u w;
    w.s_fmt = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    return w;
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    inst_word_u w;
    w.b_fmt = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    return w;
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    inst_word_u w;
    w.u_fmt = {imm, rd, opc};
    return w;
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
    inst_word_u w;
    w.j_fmt = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    return w;
  endfunction

  task automatic set_row(input int idx, input logic [31:0] word, input op_kind_e kind,
                         input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [31:0] imm, input logic [3:0] flags);
    row_word[idx] = word;
    row_op[idx] = '{op: kind, rd: rd, rs1: rs1, rs2: rs2, imm: imm, branch: flags[3],
                    ls: flags[2], use_imm: flags[1], jalr: flags[0], addr: '0};
  endtask

  // flags column is {branch, ls, use_imm, jalr}
  task automatic fill_table();
    set_row(0,  r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'b0110011), OP_ADD,
            5'd3, 5'd1, 5'd2, 32'h0, 4'b0000);
    set_row(1,  i_word(12'hff8, 5'd6, 3'd2, 5'd5, 7'b0000011), OP_LW,
            5'd5, 5'd6, 5'd0, 32'hffff_fff8, 4'b0110);
    set_row(2,  i_word(12'h123, 5'd0, 3'd0, 5'd7, 7'b0010011), OP_ADDI,
            5'd7, 5'd0, 5'd0, 32'h0000_0123, 4'b0010);
    set_row(3,  s_word(12'hffc, 5'd8, 5'd9, 3'd2), OP_SW,
            5'd0, 5'd9, 5'd8, 32'hffff_fffc, 4'b0110);
    set_row(4,  b_word(13'd16, 5'd2, 5'd1, 3'd0), OP_BEQ,
            5'd0, 5'd1, 5'd2, 32'h0000_0010, 4'b1000);
    set_row(5,  u_word(20'habcde, 5'd10, 7'b0110111), OP_LUI,
            5'd10, 5'd0, 5'd0, 32'habcd_e000, 4'b0010);
    set_row(6,  j_word(21'h1ff800, 5'd1), OP_JAL,
            5'd1, 5'd0, 5'd0, 32'hffff_f800, 4'b0010);
    set_row(7,  i_word(12'h004, 5'd1, 3'd0, 5'd0, 7'b1100111), OP_JALR,
            5'd0, 5'd1, 5'd0, 32'h0000_0004, 4'b0011);
    // unknown opcode decodes to an all-zero op
    set_row(8,  32'hffff_ffff, OP_ILLEGAL, 5'd0, 5'd0, 5'd0, 32'h0, 4'b0000);
    set_row(9,  r_word(7'h20, 5'd6, 5'd5, 3'd0, 5'd4, 7'b0110011), OP_SUB,
            5'd4, 5'd5, 5'd6, 32'h0, 4'b0000);
    set_row(10, i_word(12'h403, 5'd12, 3'd5, 5'd11, 7'b0010011), OP_SRAI,
            5'd11, 5'd12, 5'd0, 32'h0000_0403, 4'b0010);
    set_row(11, b_word(13'h1ffc, 5'd4, 5'd3, 3'd1), OP_BNE,
            5'd0, 5'd3, 5'd4, 32'hffff_fffc, 4'b1000);
    set_row(12, u_word(20'h00001, 5'd13, 7'b0010111), OP_AUIPC,
            5'd13, 5'd0, 5'd0, 32'h0000_1000, 4'b0010);
    set_row(13, i_word(12'h7ff, 5'd15, 3'd4, 5'd14, 7'b0000011), OP_LBU,
            5'd14, 5'd15, 5'd0, 32'h0000_07ff, 4'b0110);
    set_row(14, s_word(12'h001, 5'd16, 5'd17, 3'd0), OP_SB,
            5'd0, 5'd17, 5'd16, 32'h0000_0001, 4'b0110);
    set_row(15, r_word(7'h00, 5'd20, 5'd19, 3'd7, 5'd18, 7'b0110011), OP_AND,
            5'd18, 5'd19, 5'd20, 32'h0, 4'b0000);
    for (int i = 0; i < ROWS; i++) begin
      u_imem.words[i] = row_word[i];
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("check failed: %s", what);
      errors++;
    end
  endtask

  // the memory image repeats every 16 words
  task automatic compare_issued(input logic [31:0] addr);
    decoded_op_t exp;
    exp = row_op[addr[5:2]];
    exp.addr = addr;
    check_field("issue_op.op", 32'(issue_op.op), 32'(exp.op));
    check_field("issue_op.rd", 32'(issue_op.rd), 32'(exp.rd));
    check_field("issue_op.rs1", 32'(issue_op.rs1), 32'(exp.rs1));
    check_field("issue_op.rs2", 32'(issue_op.rs2), 32'(exp.rs2));
    check_field("issue_op.imm", issue_op.imm, exp.imm);
    check_field("issue_op.branch", 32'(issue_op.branch), 32'(exp.branch));
    check_field("issue_op.ls", 32'(issue_op.ls), 32'(exp.ls));
    check_field("issue_op.use_imm", 32'(issue_op.use_imm), 32'(exp.use_imm));
    check_field("issue_op.jalr", 32'(issue_op.jalr), 32'(exp.jalr));
    check_field("issue_op.addr", issue_op.addr, exp.addr);
  endtask

  task automatic start_test();
    test_num++;
    err_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == err_start) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", test_num, name, errors - err_start);
      tests_failed++;
    end
  endtask

  task automatic wait_pops(input int n);
    int target;
    target = pop_count + n;
    wait (pop_count >= target);
  endtask

  // flush is applied by the driver on the next rising edge
  task automatic request_flush(input logic [31:0] pc);
    flush_pc = pc;
    flush_req = 1'b1;
    repeat (2) @(negedge clk_in);
  endtask

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  initial begin
    arst_n = 1'b0;
    rdy = 1'b1;
    predict_fail = 1'b0;
    redirect_pc = '0;
    issue_stall = 1'b0;
  end

  // single driver for all DUT inputs after time zero
  always @(posedge clk_in) begin
    logic [31:0] rnd;
    rnd = $random(seed);
    if (flush_req) begin
      predict_fail <= 1'b1;
      redirect_pc  <= flush_pc;
      rdy          <= 1'b1;
      issue_stall  <= (mode == MODE_HOLD);
      flush_req = 1'b0;
    end else begin
      predict_fail <= 1'b0;
      case (mode)
        MODE_HOLD: begin
          rdy         <= 1'b1;
          issue_stall <= 1'b1;
        end
        MODE_RANDOM: begin
          rdy         <= (rnd[1:0] != 2'b00);
          issue_stall <= (rnd[3:2] == 2'b00);
        end
        default: begin
          rdy         <= 1'b1;
          issue_stall <= 1'b0;
        end
      endcase
    end
  end

  // pops and flushes seen on the falling edge
  always @(negedge clk_in) begin
    if (arst_n) begin
      if (imem_req) begin
        req_count++;
      end
      if (rdy && predict_fail) begin
        exp_addr = redirect_pc;
        after_flush = 1'b1;
        req_count = 0;
      end else if (rdy && issue_valid && !issue_stall) begin
        if (after_flush) begin
          check_true(issue_op.addr == exp_addr, "first op after flush not at redirect_pc");
        end
        compare_issued(exp_addr);
        exp_addr = exp_addr + 32'd4;
        pop_count++;
        after_flush = 1'b0;
      end
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: issue stage received too few ops");
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    decoded_op_t head;
    fill_table();
    repeat (2) @(posedge clk_in);
    arst_n <= 1'b1;

    start_test();
    @(negedge clk_in);
    check_field("issue_valid", 32'(issue_valid), 32'h0);
    check_field("queue_full", 32'(queue_full), 32'h0);
    check_true(issue_op == '0, "issue_op not all zero while queue empty");
    while (!imem_req) begin
      @(negedge clk_in);
    end
    check_field("imem_addr", imem_addr, `RESET_PC);
    end_test("reset");

    start_test();
    wait_pops(16);
    end_test("decode");

    start_test();
    mode = MODE_HOLD;
    request_flush(32'h0000_0040);
    while (!queue_full) begin
      @(negedge clk_in);
    end
    check_field("requests before full", req_count, `FOQ_SIZE - 1);
    check_true(issue_valid, "queue full but head not valid");
    head = issue_op;
    repeat (5) begin
      @(negedge clk_in);
      check_true(issue_op == head, "head changed while stalled");
      check_true(queue_full, "queue_full dropped while stalled");
    end
    mode = MODE_STEADY;
    wait_pops(16);
    end_test("back-pressure");

    start_test();
    mode = MODE_RANDOM;
    wait_pops(32);
    end_test("random latency and pauses");

    start_test();
    wait_pops(6);
    // aim the flush at a cycle with a read in flight
    while (!imem_req) begin
      @(negedge clk_in);
    end
    request_flush(32'h0000_0100);
    wait_pops(10);
    while (!imem_req) begin
      @(negedge clk_in);
    end
    request_flush(32'h0000_0234);
    wait_pops(12);
    end_test("flush and redirect");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_num, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_front.f
+incdir+include
verilog/fetch_front_pkg.sv
verilog/pc_counter.sv
verilog/fetch_ctrl.sv
verilog/inst_decoder.sv
verilog/op_queue.sv
verilog/fetch_front.sv
bench/imem_model.sv
bench/fetch_front_tb.sv

//--- Bender.yml
package:
  name: fetch_front

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fetch_front_pkg.sv
      - verilog/pc_counter.sv
      - verilog/fetch_ctrl.sv
      - verilog/inst_decoder.sv
      - verilog/op_queue.sv
      - verilog/fetch_front.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/imem_model.sv
      - bench/fetch_front_tb.sv
